// ==== files.f ====
+incdir+.
rc_input_pkg.sv
pulse_bus_if.sv
pwm_reader.sv
sample_arbiter.sv
channel_table.sv
rc_input_top.sv
tb_rc_input.sv

// ==== tb_rc_input.sv ====
`include "rc_input_defs.svh"

module tb_rc_input;
  import rc_input_pkg::*;

  localparam int num_rows   = 6;
  localparam int wait_limit = 200;
  localparam int quiet_len  = 50;

  // One stimulus row, channel c pulses for high + c*step cycles and all pulses end together
  // A nonzero glitch drops the line low for one cycle that many cycles into the pulse
  typedef struct packed {
    logic [3:0]  mask;
    logic [15:0] high;
    logic [15:0] glitch;
    logic [15:0] step;
    logic [15:0] exp_width;
    logic [7:0]  inc;
  } row_t;

  logic                        us_clk;
  logic                        resetn;
  logic [`RC_NUM_CHANNELS-1:0] pwm;
  channel_id_t                 rd_channel;
  pulse_us_t                   rd_width;
  update_count_t               rd_count;

  row_t          rows        [num_rows];
  pulse_us_t     model_width [`RC_NUM_CHANNELS];
  update_count_t model_count [`RC_NUM_CHANNELS];
  integer        seed;

  rc_input_top UUT (
    .us_clk     (us_clk),
    .resetn     (resetn),
    .pwm        (pwm),
    .rd_channel (rd_channel),
    .rd_width   (rd_width),
    .rd_count   (rd_count)
  );

  // One microsecond clock, 8 time units per period
  initial us_clk = 1'b0;
  always #4 us_clk = ~us_clk;

  task automatic load_table();
    // Single channel in range, then both clamp limits
    rows[0] = '{4'b0001, 16'd1200, 16'd0, 16'd0, 16'd1200, 8'd1};
    rows[1] = '{4'b0010, 16'd300, 16'd0, 16'd0, 16'd1000, 8'd1};
    rows[2] = '{4'b0100, 16'd2600, 16'd0, 16'd0, 16'd2000, 8'd1};
    // Low glitch inside a pulse and a lone high spike
    rows[3] = '{4'b1000, 16'd1400, 16'd700, 16'd0, 16'd1400, 8'd1};
    rows[4] = '{4'b0001, 16'd1, 16'd0, 16'd0, 16'd0, 8'd0};
    // All four channels end in the same cycle with different widths
    rows[5] = '{4'b1111, 16'd1100, 16'd0, 16'd150, 16'd1100, 8'd1};
  endtask

  task automatic fail_run();
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic compare_width(input string name, input pulse_us_t got, input pulse_us_t exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
      fail_run();
    end
  endtask

  task automatic compare_count(input string name, input update_count_t got,
                               input update_count_t exp);
    if (got !== exp) begin
      $display("** Error at time %0t: %s = %0d, expected %0d", $time, name, got, exp);
      fail_run();
    end
  endtask

  // The read port is registered, so data is sampled one falling edge after the address
  task automatic check_channel(input int c);
    @(negedge us_clk);
    rd_channel = channel_id_t'(c);
    @(negedge us_clk);
    compare_width($sformatf("rd_width[%0d]", c), rd_width, model_width[c]);
    compare_count($sformatf("rd_count[%0d]", c), rd_count, model_count[c]);
  endtask

  // Poll until the channel's count reaches the model value
  task automatic wait_update(input int c);
    int cycles;
    cycles = 0;
    @(negedge us_clk);
    rd_channel = channel_id_t'(c);
    @(negedge us_clk);
    while (rd_count !== model_count[c]) begin
      if (cycles >= wait_limit) begin
        $display("Timeout: channel %0d never updated within %0d cycles", c, wait_limit);
        fail_run();
      end
      cycles++;
      @(negedge us_clk);
    end
  endtask

  // A filtered spike must leave the count alone for the whole window
  task automatic watch_quiet(input int c);
    @(negedge us_clk);
    rd_channel = channel_id_t'(c);
    repeat (quiet_len) begin
      @(negedge us_clk);
      compare_count($sformatf("rd_count[%0d]", c), rd_count, model_count[c]);
    end
  endtask

  task automatic drive_pulses(input row_t r);
    int hmax;
    int start;
    for (int c = 0; c < `RC_NUM_CHANNELS; c++) begin
      if (r.mask[c] && (int'(r.high) + c * int'(r.step) > hmax)) begin
        hmax = int'(r.high) + c * int'(r.step);
      end
    end
    for (int t = 0; t < hmax; t++) begin
      @(negedge us_clk);
      for (int c = 0; c < `RC_NUM_CHANNELS; c++) begin
        // Later start for shorter pulses so every line falls in the same cycle
        start  = hmax - (int'(r.high) + c * int'(r.step));
        pwm[c] = r.mask[c] && (t >= start) &&
                 !((r.glitch != 0) && (t - start == int'(r.glitch)));
      end
    end
    @(negedge us_clk);
    pwm = '0;
  endtask

  task automatic idle_gap();
    int gap;
    gap = 20 + ($unsigned($random(seed)) % 40);
    repeat (gap) @(negedge us_clk);
  endtask

  initial begin
    pwm        = '0;
    rd_channel = '0;
    resetn     = 1'b0;
    seed       = 32'hd63c;
    load_table();
    for (int c = 0; c < `RC_NUM_CHANNELS; c++) begin
      model_width[c] = pulse_us_t'(`RC_DEFAULT_PULSE_US);
      model_count[c] = '0;
    end
    repeat (10) @(negedge us_clk);
    resetn = 1'b1;

    // Reset contents of the table
    for (int c = 0; c < `RC_NUM_CHANNELS; c++) begin
      check_channel(c);
    end

    for (int r = 0; r < num_rows; r++) begin
      idle_gap();
      drive_pulses(rows[r]);
      for (int c = 0; c < `RC_NUM_CHANNELS; c++) begin
        if (rows[r].mask[c] && (rows[r].inc != 0)) begin
          model_width[c] = pulse_us_t'(int'(rows[r].exp_width) + c * int'(rows[r].step));
          model_count[c] = model_count[c] + rows[r].inc;
        end
      end
      // Untouched channels are read too, to catch a write to the wrong entry
      for (int c = 0; c < `RC_NUM_CHANNELS; c++) begin
        if (rows[r].mask[c] && (rows[r].inc != 0)) begin
          wait_update(c);
        end else if (rows[r].mask[c]) begin
          watch_quiet(c);
        end
        check_channel(c);
      end
    end

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// ==== rc_input_top.sv ====
`include "rc_input_defs.svh"

module rc_input_top (
  input  logic                        us_clk,
  input  logic                        resetn,
  input  logic [`RC_NUM_CHANNELS-1:0] pwm,
  input  rc_input_pkg::channel_id_t   rd_channel,
  output rc_input_pkg::pulse_us_t     rd_width,
  output rc_input_pkg::update_count_t rd_count
);
  import rc_input_pkg::*;

  // Table write port driven by the arbiter
  logic        tbl_wr_en;
  channel_id_t tbl_wr_channel;
  pulse_us_t   tbl_wr_width;

  // One credit link per reader
  pulse_bus_if pulse_bus [`RC_NUM_CHANNELS] ();

  for (genvar i = 0; i < `RC_NUM_CHANNELS; i++) begin : g_reader
    pwm_reader u_reader (
      .us_clk (us_clk),
      .resetn (resetn),
      .pwm    (pwm[i]),
      .bus    (pulse_bus[i])
    );
  end

  // Serializes the readers into the single table write port
  sample_arbiter u_arbiter (
    .us_clk         (us_clk),
    .resetn         (resetn),
    .bus            (pulse_bus),
    .tbl_wr_en      (tbl_wr_en),
    .tbl_wr_channel (tbl_wr_channel),
    .tbl_wr_width   (tbl_wr_width)
  );

  channel_table u_table (
    .us_clk     (us_clk),
    .resetn     (resetn),
    .wr_en      (tbl_wr_en),
    .wr_channel (tbl_wr_channel),
    .wr_width   (tbl_wr_width),
    .rd_channel (rd_channel),
    .rd_width   (rd_width),
    .rd_count   (rd_count)
  );

endmodule

// ==== channel_table.sv ====
`include "rc_input_defs.svh"

module channel_table (
  input  logic                        us_clk,
  input  logic                        resetn,
  input  logic                        wr_en,
  input  rc_input_pkg::channel_id_t   wr_channel,
  input  rc_input_pkg::pulse_us_t     wr_width,
  input  rc_input_pkg::channel_id_t   rd_channel,
  output rc_input_pkg::pulse_us_t     rd_width,
  output rc_input_pkg::update_count_t rd_count
);
  import rc_input_pkg::*;

  // Latest width and update count for each channel
  pulse_us_t     width_mem [`RC_NUM_CHANNELS];
  update_count_t count_mem [`RC_NUM_CHANNELS];

  // Every entry starts at the neutral stick width with no updates seen
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      for (int c = 0; c < `RC_NUM_CHANNELS; c++) begin
        width_mem[c] <= pulse_us_t'(`RC_DEFAULT_PULSE_US);
        count_mem[c] <= '0;
      end
    end else if (wr_en) begin
      width_mem[wr_channel] <= wr_width;
      // The count wraps and the flight controller only looks for a change
      count_mem[wr_channel] <= count_mem[wr_channel] + 1'b1;
    end
  end

  // Read data appears one cycle after rd_channel
  // A read of the entry being written returns the old contents
  always_ff @(posedge us_clk) begin
    rd_width <= width_mem[rd_channel];
    rd_count <= count_mem[rd_channel];
  end

endmodule

// ==== sample_arbiter.sv ====
`include "rc_input_defs.svh"

module sample_arbiter (
  input  logic                      us_clk,
  input  logic                      resetn,
  pulse_bus_if.arbiter              bus [`RC_NUM_CHANNELS],
  output logic                      tbl_wr_en,
  output rc_input_pkg::channel_id_t tbl_wr_channel,
  output rc_input_pkg::pulse_us_t   tbl_wr_width
);
  import rc_input_pkg::*;

  localparam int n_ports = `RC_NUM_CHANNELS;
  localparam int depth   = `RC_PORT_CREDITS;
  localparam int ptr_w   = (depth > 1) ? $clog2(depth) : 1;
  localparam int fill_w  = $clog2(depth + 1);

  logic [n_ports-1:0] in_valid;
  pulse_us_t          in_width [n_ports];
  logic [n_ports-1:0] pop;

  // One small FIFO per port, sized to the port's credits so it cannot overflow
  pulse_us_t          fifo_mem [n_ports][depth];
  logic [ptr_w-1:0]   wr_ptr   [n_ports];
  logic [ptr_w-1:0]   rd_ptr   [n_ports];
  logic [fill_w-1:0]  fill     [n_ports];

  channel_id_t        last_grant;
  channel_id_t        grant_idx;
  channel_id_t        cand;
  logic               grant_found;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    if (ptr == ptr_w'(depth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  for (genvar i = 0; i < n_ports; i++) begin : g_port
    assign in_valid[i] = bus[i].sample_valid;
    assign in_width[i] = bus[i].sample_width;
    // The credit goes back in the same cycle the entry reaches the table
    assign pop[i]               = grant_found && (grant_idx == channel_id_t'(i));
    assign bus[i].credit_return = pop[i];
  end

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      for (int p = 0; p < n_ports; p++) begin
        wr_ptr[p] <= '0;
        rd_ptr[p] <= '0;
        fill[p]   <= '0;
      end
    end else begin
      for (int p = 0; p < n_ports; p++) begin
        if (in_valid[p]) begin
          wr_ptr[p] <= next_ptr(wr_ptr[p]);
        end
        if (pop[p]) begin
          rd_ptr[p] <= next_ptr(rd_ptr[p]);
        end
        fill[p] <= fill[p] + fill_w'(in_valid[p]) - fill_w'(pop[p]);
      end
    end
  end

  always_ff @(posedge us_clk) begin
    for (int p = 0; p < n_ports; p++) begin
      if (in_valid[p]) begin
        fifo_mem[p][wr_ptr[p]] <= in_width[p];
      end
    end
  end

  // Round-robin search starts at the port just after the last grant
  always_comb begin
    grant_found = 1'b0;
    grant_idx   = last_grant;
    cand        = last_grant;
    for (int k = 1; k <= n_ports; k++) begin
      cand = channel_id_t'((int'(last_grant) + k) % n_ports);
      if (!grant_found && (fill[cand] != '0)) begin
        grant_found = 1'b1;
        grant_idx   = cand;
      end
    end
  end

  // Port 0 wins first after reset
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      last_grant <= channel_id_t'(n_ports - 1);
    end else if (grant_found) begin
      last_grant <= grant_idx;
    end
  end

  // A sample pushed in one cycle is visible to the grant in the next one
  assign tbl_wr_en      = grant_found;
  assign tbl_wr_channel = grant_idx;
  assign tbl_wr_width   = fifo_mem[grant_idx][rd_ptr[grant_idx]];

endmodule

// ==== pwm_reader.sv ====
`include "rc_input_defs.svh"

module pwm_reader (
  input  logic        us_clk,
  input  logic        resetn,
  input  logic        pwm,
  pulse_bus_if.reader bus
);
  import rc_input_pkg::*;

  localparam int filt_w   = $clog2(`RC_FILTER_SAMPLES + 1);
  localparam int credit_w = $clog2(`RC_PORT_CREDITS + 1);

  reader_state_t       state;

  // Glitch filter state
  logic                filt_level;
  logic [filt_w-1:0]   filt_cnt;
  logic                filt_change;

  // Pulse measurement
  pulse_us_t           high_count;
  pulse_us_t           clamped_width;
  logic                new_sample;

  // Credit flow toward the arbiter
  logic [credit_w-1:0] credits;
  logic                send;
  logic                pending_valid;
  pulse_us_t           pending_width;

  // The filtered level flips on the sample that completes a run of
  // RC_FILTER_SAMPLES values different from it
  assign filt_change = (pwm != filt_level) &&
                       (filt_cnt == filt_w'(`RC_FILTER_SAMPLES - 1));

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      filt_level <= 1'b0;
      filt_cnt   <= '0;
    end else if (pwm == filt_level) begin
      // A sample matching the current level cancels any pending change
      filt_cnt <= '0;
    end else if (filt_change) begin
      filt_level <= pwm;
      filt_cnt   <= '0;
    end else begin
      filt_cnt <= filt_cnt + 1'b1;
    end
  end

  // Both edges see the same filter delay, so the cycles between the
  // accepted rise and the accepted fall equal the true high time
  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      state      <= st_init;
      high_count <= '0;
    end else begin
      case (state)
        st_init: begin
          state      <= st_low;
          high_count <= '0;
        end
        st_low: begin
          // The cycle of the accepted rise is the first counted one
          if (filt_change && pwm) begin
            state      <= st_rise;
            high_count <= pulse_us_t'(1);
          end
        end
        st_rise, st_high: begin
          if (filt_change && !pwm) begin
            state <= st_fall;
          end else begin
            state <= st_high;
            // Saturate on a stuck-high line instead of wrapping
            if (high_count != '1) begin
              high_count <= high_count + 1'b1;
            end
          end
        end
        st_fall: begin
          // Only a very short filter can accept a new rise here
          if (filt_change && pwm) begin
            state      <= st_rise;
            high_count <= pulse_us_t'(1);
          end else begin
            state <= st_low;
          end
        end
        default: begin
          state      <= st_init;
          high_count <= '0;
        end
      endcase
    end
  end

  // Keep reported widths inside the servo range
  always_comb begin
    if (high_count < pulse_us_t'(`RC_MIN_PULSE_US)) begin
      clamped_width = pulse_us_t'(`RC_MIN_PULSE_US);
    end else if (high_count > pulse_us_t'(`RC_MAX_PULSE_US)) begin
      clamped_width = pulse_us_t'(`RC_MAX_PULSE_US);
    end else begin
      clamped_width = high_count;
    end
  end

  // A finished pulse is ready during the single st_fall cycle
  assign new_sample = (state == st_fall);

  // A fresh width goes out before a pending one, which it replaces anyway
  assign send = (new_sample || pending_valid) && (credits != '0);

  always_ff @(posedge us_clk or negedge resetn) begin
    if (!resetn) begin
      credits          <= credit_w'(`RC_PORT_CREDITS);
      pending_valid    <= 1'b0;
      bus.sample_valid <= 1'b0;
    end else begin
      bus.sample_valid <= send;
      // Each valid spends a credit, each return from the arbiter refunds one
      credits <= credits - credit_w'(send) + credit_w'(bus.credit_return);
      if (new_sample && !send) begin
        pending_valid <= 1'b1;
      end else if (send) begin
        pending_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge us_clk) begin
    if (send) begin
      bus.sample_width <= new_sample ? clamped_width : pending_width;
    end
    // Without a credit the newest width waits here and overwrites older ones
    if (new_sample && !send) begin
      pending_width <= clamped_width;
    end
  end

endmodule

// ==== pulse_bus_if.sv ====
// Link from one pwm_reader to the shared sample_arbiter
// The reader may only raise sample_valid while it holds a credit
// and the arbiter hands one credit back per buffered entry it drains
interface pulse_bus_if;
  import rc_input_pkg::*;

  // One-cycle strobe, a clamped width is on sample_width
  logic      sample_valid;
  pulse_us_t sample_width;

  // One-cycle pulse when the arbiter writes an entry of this port to the table
  logic      credit_return;

  // Reader side
  modport reader (
    output sample_valid,
    output sample_width,
    input  credit_return
  );

  // Arbiter side
  modport arbiter (
    input  sample_valid,
    input  sample_width,
    output credit_return
  );

endinterface

// ==== rc_input_pkg.sv ====
`include "rc_input_defs.svh"

package rc_input_pkg;

  // Pulse width in microseconds, one count per us_clk cycle
  typedef logic [15:0] pulse_us_t;

  // Index of a PWM channel
  typedef logic [$clog2(`RC_NUM_CHANNELS)-1:0] channel_id_t;

  // Number of table updates a channel has seen, wraps at 255
  typedef logic [7:0] update_count_t;

  // Reader FSM, the filtered line level plus one-cycle edge states
  typedef enum logic [2:0] {
    st_init,
    st_low,
    st_rise,
    st_high,
    st_fall
  } reader_state_t;

endpackage

// ==== rc_input_defs.svh ====
`ifndef RC_INPUT_DEFS_SVH
`define RC_INPUT_DEFS_SVH

// Number of receiver PWM lines, one reader each
`define RC_NUM_CHANNELS 4

// Legal servo pulse range in microseconds, measured widths are clamped to it
`define RC_MIN_PULSE_US 1000
`define RC_MAX_PULSE_US 2000

// Width the table reports for a channel until its first pulse arrives
`define RC_DEFAULT_PULSE_US 1500

// Arbiter buffer slots per reader, equal to the reader's starting credit count
`define RC_PORT_CREDITS 2

// Equal consecutive samples needed before the filtered level may change
`define RC_FILTER_SAMPLES 2

`endif
